// File: hw/bus_pkg.sv
//**************************************************************************
// Read-only AXI-lite style bus shared by the fetch unit, the data port and
// the memory. Ready signals travel as separate wires against each struct.
// rresp is always OKAY and no write channels exist on this bus.
//**************************************************************************

package bus_pkg;

	localparam int addr_w = 64; // byte address width of the read bus.
	localparam int data_w = 64; // one bus beat carries one 64-bit word.

	// address channel, driven by a master toward the memory.
	typedef struct packed {
		logic [addr_w-1:0] araddr;
		logic [2:0]        arprot;
		logic              arvalid;
	} ar_req_t;

	// read data channel, driven by the memory back to a master.
	typedef struct packed {
		logic [data_w-1:0] rdata;
		logic [1:0]        rresp;
		logic              rvalid;
	} r_resp_t;

endpackage

// File: hw/core_pkg.sv
//**************************************************************************
// Core-side types for the fetch front end. Fetch words are 64 bits and the
// PC is carried unaligned, so a misaligned redirect target is kept as is.
//**************************************************************************

package core_pkg;

	typedef logic [63:0] pc_t;
	typedef logic [63:0] instr_t;

	localparam pc_t reset_vector = 64'h8000_0000; // first fetch after reset.

	// one slot of the instruction queue.
	typedef struct packed {
		pc_t    pc;
		instr_t instr;
	} fetch_entry_t;

endpackage

// File: hw/pc_gen.sv
//**************************************************************************
// Next fetch PC. Steps by one 8-byte word per taken address and loads the
// redirect target on flush. No alignment is forced on the target.
//**************************************************************************

`timescale 1ns/1ps

module pc_gen
	import core_pkg::*;
(
	input  logic CLK,
	input  logic arst_n,
	input  logic flush,
	input  pc_t  redirect_pc,
	input  logic fetch_ready,
	output pc_t  fetch_addr
);

	pc_t next_pc;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			next_pc <= reset_vector;
		end else if (flush) begin
			next_pc <= redirect_pc; // a flush wins over a fetch in the same cycle.
		end else if (fetch_ready) begin
			next_pc <= next_pc + pc_t'(8); // the fetch unit took this address.
		end
	end

	assign fetch_addr = next_pc;

endmodule

// File: hw/ifetch.sv
//**************************************************************************
// Fetch unit with a single read in flight. A new read is issued at boot or
// when the queue takes the previous entry, so a full queue stalls fetching.
// A response that a flush made stale is drained and never presented.
//**************************************************************************

`timescale 1ns/1ps

module ifetch
	import bus_pkg::*;
	import core_pkg::*;
(
	input  logic         CLK,
	input  logic         arst_n,
	input  logic         flush,
	input  pc_t          fetch_addr,
	output logic         fetch_ready,
	output ar_req_t      ar,
	input  logic         arready,
	input  r_resp_t      r,
	output logic         rready,
	output fetch_entry_t iq_entry,
	output logic         iq_valid,
	input  logic         iq_ready
);

	localparam logic [2:0] arprot_instr = 3'b100; // bit 2 marks an instruction access.

	logic              boot;
	logic              pending;
	logic              invalid_outstanding;
	logic              arvalid_q;
	logic              rready_q;
	logic              iq_valid_q;
	logic [addr_w-1:0] araddr_q;
	pc_t               pending_pc;
	fetch_entry_t      entry_q;

	logic fetch_go;
	logic ar_xfer;
	logic r_xfer;
	logic rready_set;
	logic stale_set;
	logic stale_done;
	logic boot_set;
	logic boot_rst;

	assign ar_xfer    = arvalid_q & arready;
	assign r_xfer     = r.rvalid & rready_q;
	assign rready_set = r.rvalid & ~rready_q; // gives a one-cycle rready pulse.
	assign fetch_go   = (boot | (iq_valid_q & iq_ready)) & ~flush;

	// a flush that meets the data transfer has nothing left to drain.
	assign stale_set  = pending & flush & ~r_xfer;
	assign stale_done = invalid_outstanding & r_xfer;
	assign boot_set   = (flush & (~pending | r_xfer)) | stale_done;
	assign boot_rst   = fetch_go & ~boot_set;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			boot                <= 1'b1;
			pending             <= 1'b0;
			invalid_outstanding <= 1'b0;
			arvalid_q           <= 1'b0;
			rready_q            <= 1'b0;
			iq_valid_q          <= 1'b0;
		end else begin
			if (boot_set) begin
				boot <= 1'b1;
			end else if (boot_rst) begin
				boot <= 1'b0;
			end
			if (fetch_go) begin
				pending <= 1'b1;
			end else if (r_xfer) begin
				pending <= 1'b0;
			end
			if (stale_set) begin
				invalid_outstanding <= 1'b1;
			end else if (stale_done) begin
				invalid_outstanding <= 1'b0;
			end
			if (fetch_go) begin
				arvalid_q <= 1'b1;
			end else if (ar_xfer) begin
				arvalid_q <= 1'b0;
			end
			rready_q <= rready_set;
			if (r_xfer & ~invalid_outstanding & ~flush) begin
				iq_valid_q <= 1'b1;
			end else if (iq_ready | flush) begin
				iq_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fetch_go) begin
			araddr_q   <= fetch_addr & ~64'h7; // the bus only sees whole words.
			pending_pc <= fetch_addr;
		end
		if (r_xfer) begin
			entry_q.pc    <= pending_pc;
			entry_q.instr <= r.rdata;
		end
	end

	assign fetch_ready = fetch_go;
	assign ar          = '{araddr: araddr_q, arprot: arprot_instr, arvalid: arvalid_q};
	assign rready      = rready_q;
	assign iq_entry    = entry_q;
	assign iq_valid    = iq_valid_q;

endmodule

// File: hw/instr_queue.sv
//**************************************************************************
// Circular FIFO of fetched entries. Flush empties it at the same edge and
// drops any entry offered in that cycle.
//**************************************************************************

`timescale 1ns/1ps

module instr_queue
	import core_pkg::*;
#(
	parameter int iq_depth = 4
) (
	input  logic         CLK,
	input  logic         arst_n,
	input  logic         flush,
	input  fetch_entry_t iq_entry,
	input  logic         iq_valid,
	output logic         iq_ready,
	output fetch_entry_t out_entry,
	output logic         out_valid,
	input  logic         out_ready
);

	localparam int ptr_w = (iq_depth > 1) ? $clog2(iq_depth) : 1;
	localparam int cnt_w = $clog2(iq_depth + 1);

	fetch_entry_t     slots [iq_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             push;
	logic             pop;

	function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(iq_depth - 1)) ? '0 : p + 1'b1; // depth need not be a power of two.
	endfunction

	assign iq_ready  = (count != cnt_w'(iq_depth));
	assign out_valid = (count != '0);
	assign out_entry = slots[rd_ptr];
	assign push      = iq_valid & iq_ready;
	assign pop       = out_valid & out_ready;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			count <= count + cnt_w'(push) - cnt_w'(pop);
		end
	end

	always_ff @(posedge CLK) begin
		if (push) begin
			slots[wr_ptr] <= iq_entry;
		end
	end

endmodule

// File: hw/bus_arbiter.sv
//**************************************************************************
// Round-robin arbiter for two read masters with one read in flight. The
// grant is combinational while idle; the bus stays busy from the address
// transfer until the data transfer, and responses go only to their owner.
//**************************************************************************

`timescale 1ns/1ps

module bus_arbiter
	import bus_pkg::*;
(
	input  logic    CLK,
	input  logic    arst_n,
	input  ar_req_t if_ar,
	output logic    if_arready,
	output r_resp_t if_r,
	input  logic    if_rready,
	input  ar_req_t dp_ar,
	output logic    dp_arready,
	output r_resp_t dp_r,
	input  logic    dp_rready,
	output ar_req_t mem_ar,
	input  logic    mem_arready,
	input  r_resp_t mem_r,
	output logic    mem_rready
);

	logic busy;
	logic owner_dp;
	logic last_dp;
	logic grant_dp;
	logic ar_xfer;
	logic r_xfer;

	// the data port wins when alone or when fetch was granted last.
	assign grant_dp = dp_ar.arvalid & (~if_ar.arvalid | ~last_dp);
	assign ar_xfer  = mem_ar.arvalid & mem_arready;
	assign r_xfer   = mem_r.rvalid & mem_rready;

	always_comb begin
		mem_ar         = grant_dp ? dp_ar : if_ar;
		mem_ar.arvalid = ~busy & (if_ar.arvalid | dp_ar.arvalid);
	end

	assign if_arready = ~busy & ~grant_dp & mem_arready; // the loser sees back-pressure.
	assign dp_arready = ~busy & grant_dp & mem_arready;

	always_comb begin
		if_r        = mem_r;
		dp_r        = mem_r;
		if_r.rvalid = mem_r.rvalid & busy & ~owner_dp;
		dp_r.rvalid = mem_r.rvalid & busy & owner_dp;
	end

	assign mem_rready = busy & (owner_dp ? dp_rready : if_rready);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			owner_dp <= 1'b0;
			last_dp  <= 1'b0;
		end else if (ar_xfer) begin
			busy     <= 1'b1;
			owner_dp <= grant_dp;
			last_dp  <= grant_dp; // priority rotates after every grant.
		end else if (r_xfer) begin
			busy <= 1'b0;
		end
	end

endmodule

// File: hw/fetch_ram.sv
//**************************************************************************
// Single-port word memory with a registered read and a load port. Addresses
// wrap modulo mem_words, which should be a power of two. A read racing a
// write to the same word returns the old word.
//**************************************************************************

`timescale 1ns/1ps

module fetch_ram
	import bus_pkg::*;
	import core_pkg::*;
#(
	parameter int mem_words = 256
) (
	input  logic    CLK,
	input  logic    arst_n,
	input  ar_req_t ar,
	output logic    arready,
	output r_resp_t r,
	input  logic    rready,
	input  logic    wr_en,
	input  pc_t     wr_addr,
	input  instr_t  wr_data
);

	localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

	logic [data_w-1:0] mem [mem_words];
	logic [data_w-1:0] rdata_q;
	logic              rvalid_q;
	logic              ar_xfer;
	logic [idx_w-1:0]  rd_idx;
	logic [idx_w-1:0]  wr_idx;

	assign rd_idx  = ar.araddr[idx_w+2:3]; // byte offset within the word is dropped.
	assign wr_idx  = wr_addr[idx_w+2:3];
	assign arready = ~rvalid_q; // one read at a time.
	assign ar_xfer = ar.arvalid & arready;
	assign r       = '{rdata: rdata_q, rresp: 2'b00, rvalid: rvalid_q};

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			rvalid_q <= 1'b0;
		end else if (ar_xfer) begin
			rvalid_q <= 1'b1;
		end else if (rready) begin
			rvalid_q <= 1'b0; // response held until the master takes it.
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_idx] <= wr_data;
		end
		if (ar_xfer) begin
			rdata_q <= mem[rd_idx];
		end
	end

endmodule

// File: hw/fetch_subsys.sv
//**************************************************************************
// Fetch front end top level. The fetch unit and the external data port
// share one read bus into the memory; the load port bypasses the bus.
//**************************************************************************

`timescale 1ns/1ps

module fetch_subsys
	import bus_pkg::*;
	import core_pkg::*;
#(
	parameter int iq_depth  = 4,
	parameter int mem_words = 256
) (
	input  logic         CLK,
	input  logic         arst_n,
	input  logic         flush,
	input  pc_t          redirect_pc,
	output fetch_entry_t out_entry,
	output logic         out_valid,
	input  logic         out_ready,
	input  ar_req_t      dp_ar,
	output logic         dp_arready,
	output r_resp_t      dp_r,
	input  logic         dp_rready,
	input  logic         wr_en,
	input  pc_t          wr_addr,
	input  instr_t       wr_data
);

	pc_t          fetch_addr;
	logic         fetch_ready;
	ar_req_t      if_ar;
	logic         if_arready;
	r_resp_t      if_r;
	logic         if_rready;
	ar_req_t      mem_ar;
	logic         mem_arready;
	r_resp_t      mem_r;
	logic         mem_rready;
	fetch_entry_t iq_entry;
	logic         iq_valid;
	logic         iq_ready;

	pc_gen u_pc_gen (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.flush      (flush),
		.redirect_pc(redirect_pc),
		.fetch_ready(fetch_ready),
		.fetch_addr (fetch_addr)
	);

	ifetch u_ifetch (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.flush      (flush),
		.fetch_addr (fetch_addr),
		.fetch_ready(fetch_ready),
		.ar         (if_ar),
		.arready    (if_arready),
		.r          (if_r),
		.rready     (if_rready),
		.iq_entry   (iq_entry),
		.iq_valid   (iq_valid),
		.iq_ready   (iq_ready)
	);

	instr_queue #(
		.iq_depth(iq_depth)
	) u_instr_queue (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.flush    (flush),
		.iq_entry (iq_entry),
		.iq_valid (iq_valid),
		.iq_ready (iq_ready),
		.out_entry(out_entry),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	bus_arbiter u_bus_arbiter (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.if_ar      (if_ar),
		.if_arready (if_arready),
		.if_r       (if_r),
		.if_rready  (if_rready),
		.dp_ar      (dp_ar),
		.dp_arready (dp_arready),
		.dp_r       (dp_r),
		.dp_rready  (dp_rready),
		.mem_ar     (mem_ar),
		.mem_arready(mem_arready),
		.mem_r      (mem_r),
		.mem_rready (mem_rready)
	);

	fetch_ram #(
		.mem_words(mem_words)
	) u_fetch_ram (
		.CLK    (CLK),
		.arst_n (arst_n),
		.ar     (mem_ar),
		.arready(mem_arready),
		.r      (mem_r),
		.rready (mem_rready),
		.wr_en  (wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

endmodule

// File: bench/fetch_assert.sv
//**************************************************************************
// Handshake assertions bound into the read arbiter. Only the master side is
// watched, with a small tracker of which master has a read in flight.
//**************************************************************************

`timescale 1ns/1ps

module fetch_assert
	import bus_pkg::*;
(
	input logic    CLK,
	input logic    arst_n,
	input ar_req_t if_ar,
	input logic    if_arready,
	input r_resp_t if_r,
	input logic    if_rready,
	input ar_req_t dp_ar,
	input logic    dp_arready,
	input r_resp_t dp_r,
	input logic    dp_rready
);

	int   fail_count = 0;
	logic if_open; // fetch read accepted and not yet answered.
	logic dp_open; // data port read accepted and not yet answered.

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			if_open <= 1'b0;
			dp_open <= 1'b0;
		end else begin
			if (if_ar.arvalid && if_arready) begin
				if_open <= 1'b1;
			end else if (if_r.rvalid && if_rready) begin
				if_open <= 1'b0;
			end
			if (dp_ar.arvalid && dp_arready) begin
				dp_open <= 1'b1;
			end else if (dp_r.rvalid && dp_rready) begin
				dp_open <= 1'b0;
			end
		end
	end

	a_if_ar_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		if_ar.arvalid && !if_arready |=> if_ar.arvalid && $stable(if_ar.araddr))
		else begin
			fail_count++;
			$error("fetch read address dropped or changed before arready");
		end

	a_dp_ar_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		dp_ar.arvalid && !dp_arready |=> dp_ar.arvalid && $stable(dp_ar.araddr))
		else begin
			fail_count++;
			$error("data port read address dropped or changed before arready");
		end

	a_if_r_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		if_r.rvalid && !if_rready |=> if_r.rvalid)
		else begin
			fail_count++;
			$error("fetch response withdrawn before rready");
		end

	a_dp_r_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		dp_r.rvalid && !dp_rready |=> dp_r.rvalid)
		else begin
			fail_count++;
			$error("data port response withdrawn before rready");
		end

	// a response goes only to the master whose read is in flight, so
	// the two masters never see rvalid together.
	a_if_r_owner: assert property (@(posedge CLK) disable iff (!arst_n)
		if_r.rvalid |-> if_open && !dp_open)
		else begin
			fail_count++;
			$error("fetch sees rvalid without owning the only read in flight");
		end

	a_dp_r_owner: assert property (@(posedge CLK) disable iff (!arst_n)
		dp_r.rvalid |-> dp_open && !if_open)
		else begin
			fail_count++;
			$error("data port sees rvalid without owning the only read in flight");
		end

endmodule

bind bus_arbiter fetch_assert u_fetch_assert (
	.CLK       (CLK),
	.arst_n    (arst_n),
	.if_ar     (if_ar),
	.if_arready(if_arready),
	.if_r      (if_r),
	.if_rready (if_rready),
	.dp_ar     (dp_ar),
	.dp_arready(dp_arready),
	.dp_r      (dp_r),
	.dp_rready (dp_rready)
);

// File: bench/tb_fetch_subsys.sv
//**************************************************************************
// Table-driven testbench for the fetch front end. Memory is loaded while a
// held flush keeps the fetch unit at its first read. Handshakes are sampled
// at the rising edge and inputs change on the falling edge.
//**************************************************************************

`timescale 1ns/1ps

module tb_fetch_subsys
	import bus_pkg::*;
	import core_pkg::*;
();

	localparam int  iq_depth  = 4;
	localparam int  mem_words = 256;
	localparam int  n_phases  = 9;
	localparam int  none      = 'hffff; // no flush or data read in this row.
	localparam pc_t rv        = reset_vector;

	typedef struct packed {
		logic [15:0] cycles;
		logic [7:0]  ready_pat;
		logic [15:0] flush_cyc;
		pc_t         target;
		logic [15:0] reload;
		logic [15:0] dp_cyc0;
		pc_t         dp_addr0;
		logic [15:0] dp_cyc1;
		pc_t         dp_addr1;
	} phase_t;

	logic         CLK;
	logic         arst_n;
	logic         flush;
	pc_t          redirect_pc;
	fetch_entry_t out_entry;
	logic         out_valid;
	logic         out_ready;
	ar_req_t      dp_ar;
	logic         dp_arready;
	r_resp_t      dp_r;
	logic         dp_rready;
	logic         wr_en;
	pc_t          wr_addr;
	instr_t       wr_data;

	phase_t      phases [n_phases];
	instr_t      bench_mem [mem_words];
	logic [31:0] lfsr_state;
	pc_t         exp_pc;
	pc_t         dp_todo [$];
	pc_t         dp_exp [$];
	int          errors;
	int          fetched;
	int          dp_issued;
	int          dp_done;
	bit          dp_taken;
	bit          table_ready = 1'b0;

	fetch_subsys #(
		.iq_depth (iq_depth),
		.mem_words(mem_words)
	) u_dut (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.flush      (flush),
		.redirect_pc(redirect_pc),
		.out_entry  (out_entry),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.dp_ar      (dp_ar),
		.dp_arready (dp_arready),
		.dp_r       (dp_r),
		.dp_rready  (dp_rready),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0); // taps 32, 22, 2 and 1.
	endfunction

	function automatic instr_t random_word();
		instr_t w;
		for (int b = 0; b < 64; b++) begin
			w[b]       = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return w;
	endfunction

	// memory words are indexed by the address bits above the byte offset.
	function automatic int word_index(input pc_t a);
		return int'((a >> 3) % mem_words);
	endfunction

	function automatic phase_t phase_row(input int cycles, input logic [7:0] pat,
			input int fcyc, input pc_t target, input int reload,
			input int d0c, input pc_t d0a, input int d1c, input pc_t d1a);
		phase_t p;
		p = '{cycles: 16'(cycles), ready_pat: pat, flush_cyc: 16'(fcyc), target: target,
			reload: 16'(reload), dp_cyc0: 16'(d0c), dp_addr0: d0a, dp_cyc1: 16'(d1c),
			dp_addr1: d1a};
		return p;
	endfunction

	task automatic report_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		errors++;
		$display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("ERROR t=%0t %s", $time, what);
	endtask

	// fetching stays parked on the held flush while words are written.
	task automatic write_words(input pc_t base, input int count);
		@(negedge CLK);
		flush       = 1'b1;
		redirect_pc = base;
		out_ready   = 1'b0;
		for (int i = 0; i < count; i++) begin
			@(negedge CLK);
			wr_en   = 1'b1;
			wr_addr = (base & ~64'h7) + pc_t'(8 * i);
			wr_data = random_word();
			bench_mem[word_index(wr_addr)] = wr_data;
		end
		@(negedge CLK);
		wr_en = 1'b0;
	endtask

	task automatic run_phase(input int n);
		phase_t p;
		int     start;
		int     c;
		bit     check_empty;
		p           = phases[n];
		check_empty = 1'b0;
		if (p.reload != 0) begin
			write_words(p.target, int'(p.reload));
		end
		start = fetched;
		for (c = 0; c < int'(p.cycles); c++) begin
			@(negedge CLK);
			if (check_empty && out_valid !== 1'b0) begin
				report_value("out_valid", 64'd0, 64'(out_valid)); // queue must be empty after flush.
			end
			check_empty = (c == int'(p.flush_cyc));
			flush       = check_empty;
			redirect_pc = p.target;
			out_ready   = p.ready_pat[c % 8];
			if (dp_taken) begin
				dp_ar    = '0;
				dp_taken = 1'b0;
			end
			if (c == int'(p.dp_cyc0)) begin
				dp_todo.push_back(p.dp_addr0);
			end
			if (c == int'(p.dp_cyc1)) begin
				dp_todo.push_back(p.dp_addr1);
			end
			if (!dp_ar.arvalid && dp_todo.size() != 0) begin
				dp_ar = '{araddr: dp_todo.pop_front(), arprot: 3'b000, arvalid: 1'b1};
				dp_issued++;
			end
		end
		if (p.ready_pat != 8'h00 && fetched == start) begin
			report_problem($sformatf("phase %0d delivered no fetched entry", n));
		end
	endtask

	// reference model for the fetch stream and the data port responses.
	always @(posedge CLK) begin : monitor
		pc_t addr;
		if (arst_n) begin
			if (flush) begin
				exp_pc = redirect_pc; // the stream restarts at the redirect target.
			end else if (out_valid && out_ready) begin
				if (out_entry.pc !== exp_pc) begin
					report_value("out_entry.pc", exp_pc, out_entry.pc);
				end
				if (out_entry.instr !== bench_mem[word_index(exp_pc)]) begin
					report_value("out_entry.instr", bench_mem[word_index(exp_pc)],
						out_entry.instr);
				end
				exp_pc = exp_pc + pc_t'(8);
				fetched++;
			end
			if (dp_ar.arvalid && dp_arready) begin
				dp_exp.push_back(dp_ar.araddr);
				dp_taken = 1'b1;
			end
			if (dp_r.rvalid && dp_rready) begin
				if (dp_exp.size() == 0) begin
					report_problem("data port response arrived with no read outstanding");
				end else begin
					addr = dp_exp.pop_front();
					if (dp_r.rdata !== bench_mem[word_index(addr)]) begin
						report_value("dp_r.rdata", bench_mem[word_index(addr)], dp_r.rdata);
					end
					if (dp_r.rresp !== 2'b00) begin
						report_value("dp_r.rresp", 64'd0, 64'(dp_r.rresp)); // always OKAY.
					end
					dp_done++;
				end
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (table_ready);
		limit = 200 + mem_words;
		for (int n = 0; n < n_phases; n++) begin
			limit += int'(phases[n].cycles) + int'(phases[n].reload) + 4;
		end
		repeat (limit) @(posedge CLK);
		$display("watchdog: the run did not finish within %0d cycles", limit);
		$display(">>> FAIL");
		$finish;
	end

	initial begin : main
		int asserts;
		arst_n      = 1'b0;
		flush       = 1'b1;
		redirect_pc = reset_vector;
		out_ready   = 1'b0;
		dp_ar       = '0;
		dp_rready   = 1'b0;
		wr_en       = 1'b0;
		wr_addr     = '0;
		wr_data     = '0;
		errors      = 0;
		fetched     = 0;
		dp_issued   = 0;
		dp_done     = 0;
		dp_taken    = 1'b0;
		lfsr_state  = 32'hcab1;
		exp_pc      = reset_vector;

		phases[0] = phase_row(60, 8'hff, none, rv, 0, none, rv, none, rv);
		phases[1] = phase_row(30, 8'h00, none, rv, 0, none, rv, none, rv); // fills the queue.
		phases[2] = phase_row(40, 8'hff, none, rv, 0, none, rv, none, rv);
		phases[3] = phase_row(50, 8'hb5, 7, rv + 64'h200, 0, none, rv, none, rv);
		phases[4] = phase_row(30, 8'h3c, 2, rv + 64'h88, 0, none, rv, none, rv);
		phases[5] = phase_row(40, 8'hff, 3, rv + 64'h303, 0, none, rv, none, rv);
		phases[6] = phase_row(60, 8'h5f, none, rv, 0, 4, rv + 64'h18, 20, rv + 64'h125);
		phases[7] = phase_row(40, 8'hff, none, rv + 64'h40, 6, none, rv, none, rv);
		phases[8] = phase_row(50, 8'hef, 10, rv + 64'h7f8, 0, 0, rv + 64'h48, 12, rv + 64'h3a0);
		table_ready = 1'b1;

		repeat (2) @(negedge CLK);
		arst_n    = 1'b1;
		dp_rready = 1'b1;
		@(negedge CLK);
		if (out_valid !== 1'b0) begin
			report_value("out_valid", 64'd0, 64'(out_valid));
		end
		if (dp_r.rvalid !== 1'b0) begin
			report_value("dp_r.rvalid", 64'd0, 64'(dp_r.rvalid));
		end

		write_words(reset_vector, mem_words);
		for (int n = 0; n < n_phases; n++) begin
			run_phase(n);
		end
		if (dp_done != dp_issued) begin
			report_problem($sformatf("%0d data reads issued but %0d answered",
				dp_issued, dp_done));
		end

		asserts = u_dut.u_bus_arbiter.u_fetch_assert.fail_count;
		$display("errors: %0d checks, %0d assertions (%0d entries, %0d data reads)",
			errors, asserts, fetched, dp_done);
		if (errors == 0 && asserts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: filelist.f
hw/bus_pkg.sv
hw/core_pkg.sv
hw/pc_gen.sv
hw/ifetch.sv
hw/instr_queue.sv
hw/bus_arbiter.sv
hw/fetch_ram.sv
hw/fetch_subsys.sv
bench/fetch_assert.sv
bench/tb_fetch_subsys.sv

// File: Bender.yml
package:
  name: fetch_subsys

sources:
  - files:
      - hw/bus_pkg.sv
      - hw/core_pkg.sv
      - hw/pc_gen.sv
      - hw/ifetch.sv
      - hw/instr_queue.sv
      - hw/bus_arbiter.sv
      - hw/fetch_ram.sv
      - hw/fetch_subsys.sv
  - target: test
    files:
      - bench/fetch_assert.sv
      - bench/tb_fetch_subsys.sv
